// ==== filelist.f ====
rtl/cart_pkg.sv
rtl/cart_cfg_if.sv
rtl/mcu_cfg_regs.sv
rtl/bsx_reg_bank.sv
rtl/address_map.sv
rtl/cart_bus_top.sv
tb/cart_bus_assert.sv
tb/tb_cart_bus.sv

// ==== rtl/address_map.sv ====
`timescale 1ns/1ps

module address_map #(
  parameter cart_pkg::mem_addr_t SAVERAM_BASE = 24'hE00000,
  parameter cart_pkg::mem_addr_t PSRAM_BASE   = 24'h400000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  cart_cfg_if.cfg_dst          cfg,
  input  cart_pkg::snes_addr_t snes_addr,
  input  cart_pkg::pa_t        snes_pa,
  input  cart_pkg::bsx_reg_t   bsx_regs,
  output cart_pkg::mem_addr_t  rom_addr,
  output logic                 rom_hit,
  output logic                 is_rom,
  output logic                 is_saveram,
  output logic                 is_writable,
  output logic                 use_bsx,
  output logic                 bsx_tristate,
  output logic                 msu_enable,
  output logic                 srtc_enable,
  output logic                 r213f_enable,
  output logic                 snescmd_rd_enable,
  output logic                 snescmd_wr_enable
);
  import cart_pkg::*;

  logic        is_rom_c, is_saveram_c, is_writable_c, use_bsx_c, tristate_c;
  logic        save_win;      // Mapper specific save RAM window
  logic [14:0] menu_off;      // Offset into menu save area
  mem_addr_t   addr_c;

  logic [2:0]  psram_bank;
  snes_addr_t  bsx_chk;
  mem_addr_t   bsx_addr;
  logic        psram_lohi, bsx_psram, bsx_cartrom, hole_lohi, bsx_hole;

  //////////////////////////////
  // Region decode
  //////////////////////////////

  assign is_rom_c = snes_addr[22] | snes_addr[15];

  always_comb begin
    case (cfg.mapper)
      MAP_HIROM, MAP_EXHIROM, MAP_MENU:  // Banks 20-3F, 6000-7FFF
        save_win = ~snes_addr[22] & snes_addr[21] & (&snes_addr[14:13]) & ~snes_addr[15];
      MAP_LOROM:
        save_win = (&snes_addr[22:20]) & (snes_addr[19:16] < 4'hE)
                 & (~snes_addr[15] | ~cfg.rom_mask[21]);
      MAP_BSX:
        save_win = (snes_addr[23:19] == 5'b00010) & (snes_addr[15:12] == 4'h5);
      default: save_win = 1'b0;
    endcase
  end

  assign is_saveram_c = cfg.saveram_mask[0] & save_win;
  assign use_bsx_c    = (cfg.mapper == MAP_BSX);

  //////////////////////////////
  // BS-X PSRAM and holes
  //////////////////////////////

  // Reg 2 picks HiROM layout, regs 5/6 the PSRAM bank
  assign psram_bank = {bsx_regs[2], bsx_regs[6], bsx_regs[5]};
  assign bsx_chk    = bsx_regs[2] ? snes_addr
                                  : {snes_addr[23], 1'b0, snes_addr[22:16], snes_addr[14:0]};
  assign psram_lohi = (bsx_regs[3] & ~snes_addr[23]) | (bsx_regs[4] & snes_addr[23]);

  assign bsx_psram = psram_lohi
                   & (((bsx_chk[22:20] == psram_bank)
                       & (snes_addr[15] | bsx_regs[2])
                       & ~(snes_addr[19] & bsx_regs[2]))
                      | (bsx_regs[2]
                         ? ((snes_addr[22:21] == 2'b01) & (snes_addr[15:13] == 3'b011))
                         : ((&snes_addr[22:20]) & ~snes_addr[15])));

  assign bsx_cartrom = ((bsx_regs[7] & (snes_addr[23:22] == 2'b00))
                        | (bsx_regs[8] & (snes_addr[23:22] == 2'b10)))
                     & snes_addr[15];

  assign hole_lohi = (bsx_regs[9] & ~snes_addr[23]) | (bsx_regs[10] & snes_addr[23]);
  assign bsx_hole  = hole_lohi
                   & (bsx_regs[2] ? (snes_addr[21:20] == {bsx_regs[11], 1'b0})
                                  : (snes_addr[22:21] == {bsx_regs[11], 1'b0}));

  assign bsx_addr = bsx_regs[2] ? {1'b0, snes_addr[22:0]}
                                : {2'b00, snes_addr[22:16], snes_addr[14:0]};

  assign tristate_c    = use_bsx_c & ~bsx_cartrom & ~bsx_psram & bsx_hole;
  assign is_writable_c = is_saveram_c | (use_bsx_c & bsx_psram);

  //////////////////////////////
  // Address translation
  //////////////////////////////

  assign menu_off = snes_addr[14:0] - 15'h6000;

  always_comb begin
    case (cfg.mapper)
      MAP_HIROM:
        addr_c = is_saveram_c
               ? SAVERAM_BASE + ({6'd0, snes_addr[20:16], snes_addr[12:0]} & cfg.saveram_mask)
               : {1'b0, snes_addr[22:0]} & cfg.rom_mask;
      MAP_LOROM:
        addr_c = is_saveram_c
               ? SAVERAM_BASE + ({4'd0, snes_addr[20:16], snes_addr[14:0]} & cfg.saveram_mask)
               : {2'b00, snes_addr[22:16], snes_addr[14:0]} & cfg.rom_mask;
      MAP_EXHIROM:  // Upper half of the ROM lives in banks 40-7D
        addr_c = is_saveram_c
               ? SAVERAM_BASE + ({6'd0, snes_addr[20:16], snes_addr[12:0]} & cfg.saveram_mask)
               : {1'b0, ~snes_addr[23], snes_addr[21:0]} & cfg.rom_mask;
      MAP_BSX: begin
        if (is_saveram_c)
          addr_c = SAVERAM_BASE + {9'd0, snes_addr[18:16], snes_addr[11:0]};
        else if (bsx_cartrom)
          addr_c = 24'h800000 + ({2'b00, snes_addr[22:16], snes_addr[14:0]} & 24'h0FFFFF);
        else if (bsx_psram)
          addr_c = PSRAM_BASE + (bsx_addr & 24'h07FFFF);  // 512 KB PSRAM
        else
          addr_c = bsx_addr & 24'h0FFFFF;
      end
      MAP_MENU:
        addr_c = is_saveram_c
               ? 24'hFF0000 + ({9'd0, menu_off} & cfg.saveram_mask)
               : ({1'b0, snes_addr[22:0]} & cfg.rom_mask) + 24'hC00000;
      default: addr_c = '0;
    endcase
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rom_addr          <= '0;
      rom_hit           <= 1'b0;
      is_rom            <= 1'b0;
      is_saveram        <= 1'b0;
      is_writable       <= 1'b0;
      use_bsx           <= 1'b0;
      bsx_tristate      <= 1'b0;
      msu_enable        <= 1'b0;
      srtc_enable       <= 1'b0;
      r213f_enable      <= 1'b0;
      snescmd_rd_enable <= 1'b0;
      snescmd_wr_enable <= 1'b0;
    end else begin
      rom_addr     <= addr_c;
      rom_hit      <= is_rom_c | is_writable_c;
      is_rom       <= is_rom_c;
      is_saveram   <= is_saveram_c;
      is_writable  <= is_writable_c;
      use_bsx      <= use_bsx_c;
      bsx_tristate <= tristate_c;
      msu_enable   <= cfg.featurebits[FEAT_MSU1] & ~snes_addr[22]
                    & (snes_addr[15:3] == 13'h0400);  // 2000-2007
      srtc_enable  <= cfg.featurebits[FEAT_SRTC] & ~snes_addr[22]
                    & (snes_addr[15:1] == 15'h1400);  // 2800-2801
      r213f_enable      <= cfg.featurebits[FEAT_213F] & (snes_pa == 8'h3F);
      snescmd_rd_enable <= (snes_pa[7:4] == 4'hE);
      snescmd_wr_enable <= (snes_addr[23:4] == 20'hCCCCC);
    end
  end

endmodule

// ==== rtl/bsx_reg_bank.sv ====
`timescale 1ns/1ps

module bsx_reg_bank (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 snes_wr,
  input  cart_pkg::snes_addr_t snes_addr,
  input  logic [7:0]           snes_data,
  output cart_pkg::bsx_reg_t   bsx_regs
);

  logic [7:0] bank;
  logic [3:0] reg_idx;
  logic       win_hit;

  assign bank    = snes_addr[23:16];
  assign reg_idx = snes_addr[19:16];  // Bank 01..0E selects the register

  // Register window is banks 01-0E, offsets 5000-5FFF
  assign win_hit = snes_wr
                 & (bank >= 8'h01)
                 & (bank <= 8'h0E)
                 & (snes_addr[15:12] == 4'h5);

  // Only bit 7 of the data carries the register value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bsx_regs <= '0;
    end else if (win_hit) begin
      bsx_regs[reg_idx] <= snes_data[7];
    end
  end

endmodule

// ==== rtl/cart_bus_top.sv ====
`timescale 1ns/1ps

module cart_bus_top #(
  parameter cart_pkg::mem_addr_t SAVERAM_BASE = 24'hE00000,
  parameter cart_pkg::mem_addr_t PSRAM_BASE   = 24'h400000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // MCU config port
  input  logic                 mcu_wr,
  input  cart_pkg::cfg_sel_t   mcu_sel,
  input  logic [7:0]           mcu_data,
  // SNES bus
  input  logic                 snes_wr,
  input  cart_pkg::snes_addr_t snes_addr,
  input  logic [7:0]           snes_data,
  input  cart_pkg::pa_t        snes_pa,
  // Mapped outputs
  output cart_pkg::mem_addr_t  rom_addr,
  output logic                 rom_hit,
  output logic                 is_rom,
  output logic                 is_saveram,
  output logic                 is_writable,
  output logic                 use_bsx,
  output logic                 bsx_tristate,
  output logic                 msu_enable,
  output logic                 srtc_enable,
  output logic                 r213f_enable,
  output logic                 snescmd_rd_enable,
  output logic                 snescmd_wr_enable
);

  cart_cfg_if         cfg_bus ();
  cart_pkg::bsx_reg_t bsx_regs;

  //////////////////////////////
  // Register banks
  //////////////////////////////

  mcu_cfg_regs u_cfg (
    .clk      (clk),
    .arst_n   (arst_n),
    .mcu_wr   (mcu_wr),
    .mcu_sel  (mcu_sel),
    .mcu_data (mcu_data),
    .cfg      (cfg_bus.cfg_src)
  );

  bsx_reg_bank u_bsx (
    .clk       (clk),
    .arst_n    (arst_n),
    .snes_wr   (snes_wr),
    .snes_addr (snes_addr),
    .snes_data (snes_data),
    .bsx_regs  (bsx_regs)
  );

  // One cycle from SNES address to mapped result
  address_map #(
    .SAVERAM_BASE (SAVERAM_BASE),
    .PSRAM_BASE   (PSRAM_BASE)
  ) u_map (
    .clk               (clk),
    .arst_n            (arst_n),
    .cfg               (cfg_bus.cfg_dst),
    .snes_addr         (snes_addr),
    .snes_pa           (snes_pa),
    .bsx_regs          (bsx_regs),
    .rom_addr          (rom_addr),
    .rom_hit           (rom_hit),
    .is_rom            (is_rom),
    .is_saveram        (is_saveram),
    .is_writable       (is_writable),
    .use_bsx           (use_bsx),
    .bsx_tristate      (bsx_tristate),
    .msu_enable        (msu_enable),
    .srtc_enable       (srtc_enable),
    .r213f_enable      (r213f_enable),
    .snescmd_rd_enable (snescmd_rd_enable),
    .snescmd_wr_enable (snescmd_wr_enable)
  );

endmodule

// ==== rtl/cart_cfg_if.sv ====
`timescale 1ns/1ps

// Static cartridge configuration, levels only
interface cart_cfg_if;
  import cart_pkg::*;

  mapper_t  mapper;
  feature_t featurebits;
  mask_t    rom_mask;
  mask_t    saveram_mask;  // Bit 0 enables save RAM

  modport cfg_src (
    output mapper,
    output featurebits,
    output rom_mask,
    output saveram_mask
  );

  modport cfg_dst (
    input mapper,
    input featurebits,
    input rom_mask,
    input saveram_mask
  );

endinterface

// ==== rtl/cart_pkg.sv ====
package cart_pkg;

  //////////////////////////////
  // Bus and memory widths
  //////////////////////////////

  typedef logic [23:0] snes_addr_t;  // Bank in 23:16, offset in 15:0
  typedef logic [23:0] mem_addr_t;   // External memory address
  typedef logic [23:0] mask_t;       // Save RAM mask bit 0 doubles as enable
  typedef logic [7:0]  pa_t;         // B-bus address

  // Mapper codes as written by the MCU
  typedef logic [2:0] mapper_t;

  localparam mapper_t MAP_HIROM   = 3'd0;
  localparam mapper_t MAP_LOROM   = 3'd1;
  localparam mapper_t MAP_EXHIROM = 3'd2;
  localparam mapper_t MAP_BSX     = 3'd3;
  localparam mapper_t MAP_MENU    = 3'd7;  // ROM sits in upper memory

  //////////////////////////////
  // Feature bits
  //////////////////////////////

  typedef logic [7:0] feature_t;

  localparam int FEAT_SRTC = 2;
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  // One bit per BS-X register, index equals the bank it sits in
  typedef logic [14:0] bsx_reg_t;

  // MCU register select
  typedef logic [2:0] cfg_sel_t;

endpackage

// ==== rtl/mcu_cfg_regs.sv ====
`timescale 1ns/1ps

module mcu_cfg_regs (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               mcu_wr,
  input  cart_pkg::cfg_sel_t mcu_sel,
  input  logic [7:0]         mcu_data,
  cart_cfg_if.cfg_src        cfg
);
  import cart_pkg::*;

  mapper_t  mapper_q;
  feature_t feat_q;
  mask_t    rom_mask_q;
  mask_t    saveram_mask_q;

  // Byte loads, one register per select code
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mapper_q       <= MAP_HIROM;
      feat_q         <= '0;
      rom_mask_q     <= 24'hFFFFFF;  // Full ROM visible
      saveram_mask_q <= '0;          // Save RAM off
    end else if (mcu_wr) begin
      case (mcu_sel)
        3'd0: mapper_q <= mcu_data[2:0];
        3'd1: feat_q <= mcu_data;
        3'd2: rom_mask_q[7:0] <= mcu_data;
        3'd3: rom_mask_q[15:8] <= mcu_data;
        3'd4: rom_mask_q[23:16] <= mcu_data;
        3'd5: saveram_mask_q[7:0] <= mcu_data;
        3'd6: saveram_mask_q[15:8] <= mcu_data;
        3'd7: saveram_mask_q[23:16] <= mcu_data;
        default: ;
      endcase
    end
  end

  assign cfg.mapper       = mapper_q;
  assign cfg.featurebits  = feat_q;
  assign cfg.rom_mask     = rom_mask_q;
  assign cfg.saveram_mask = saveram_mask_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cart_bus -f filelist.f -o sim_cart_bus
./obj_dir/sim_cart_bus | tee sim.log

# An assertion stop leaves neither summary line in the log
if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== tb/cart_bus_assert.sv ====
`timescale 1ns/1ps

module cart_bus_assert (
  input logic                clk,
  input logic                arst_n,
  input cart_pkg::mem_addr_t rom_addr,
  input logic                rom_hit,
  input logic                is_rom,
  input logic                is_saveram,
  input logic                is_writable,
  input logic                use_bsx,
  input logic                bsx_tristate,
  input logic                msu_enable,
  input logic                srtc_enable,
  input logic                r213f_enable,
  input logic                snescmd_rd_enable,
  input logic                snescmd_wr_enable
);

  logic [10:0] flags;

  assign flags = {rom_hit, is_rom, is_saveram, is_writable, use_bsx, bsx_tristate,
                  msu_enable, srtc_enable, r213f_enable, snescmd_rd_enable, snescmd_wr_enable};

  ////////////////////////////////
  // Region flags nest
  ////////////////////////////////

  a_wr_hit: assert property (@(posedge clk) disable iff (!arst_n) is_writable |-> rom_hit)
    else $error("is_writable set without rom_hit");

  a_sav_wr: assert property (@(posedge clk) disable iff (!arst_n) is_saveram |-> is_writable)
    else $error("is_saveram set without is_writable");

  a_tri_bsx: assert property (@(posedge clk) disable iff (!arst_n) bsx_tristate |-> use_bsx)
    else $error("bsx_tristate set outside the BS-X mapper");

  // Outputs held clear in reset
  a_reset: assert property (@(posedge clk) !arst_n |-> (rom_addr == '0) && (flags == '0))
    else $error("outputs not cleared during reset");

endmodule

bind address_map cart_bus_assert u_assert (
  .clk               (clk),
  .arst_n            (arst_n),
  .rom_addr          (rom_addr),
  .rom_hit           (rom_hit),
  .is_rom            (is_rom),
  .is_saveram        (is_saveram),
  .is_writable       (is_writable),
  .use_bsx           (use_bsx),
  .bsx_tristate      (bsx_tristate),
  .msu_enable        (msu_enable),
  .srtc_enable       (srtc_enable),
  .r213f_enable      (r213f_enable),
  .snescmd_rd_enable (snescmd_rd_enable),
  .snescmd_wr_enable (snescmd_wr_enable)
);

// ==== tb/tb_cart_bus.sv ====
`timescale 1ns/1ps

module tb_cart_bus;
  import cart_pkg::*;

  localparam int        PERIOD  = 4;
  localparam int        N_VEC   = 40;
  localparam mem_addr_t SR_BASE = 24'hE00000;
  localparam mem_addr_t PS_BASE = 24'h400000;
  // Two cycles per access or register write
  localparam int RUN_CYCLES = 12 + 4 * (8 + 2 * N_VEC) + 2 * (6 + 5 * (2 + 2 * N_VEC))
                            + 2 + 8 * N_VEC + 4 * (2 + 2 * N_VEC);

  logic       clk, arst_n, mcu_wr, snes_wr;
  cfg_sel_t   mcu_sel;
  logic [7:0] mcu_data, snes_data;
  snes_addr_t snes_addr;
  pa_t        snes_pa;
  mem_addr_t  rom_addr;
  logic       rom_hit, is_rom, is_saveram, is_writable, use_bsx, bsx_tristate;
  logic       msu_enable, srtc_enable, r213f_enable, snescmd_rd_enable, snescmd_wr_enable;

  // Model copies of the register state
  mapper_t   m_map;
  feature_t  m_feat;
  mask_t     m_rmask, m_smask;
  bsx_reg_t  m_bsx;
  mem_addr_t e_addr;
  logic      e_hit, e_rom, e_sav, e_wr, e_bsx, e_tri, e_msu, e_srtc, e_213f, e_cmdrd, e_cmdwr;

  logic [15:0] lfsr;
  logic [23:0] r, q;
  pa_t         p;
  int          errs, test_errs, n_tests, n_failed;

  cart_bus_top #(.SAVERAM_BASE(SR_BASE), .PSRAM_BASE(PS_BASE)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RUN_CYCLES + 200) * PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES + 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Polynomial x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [23:0] rand_bits(input int n);
    logic [23:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[22:0], fb};
    end
    return v;
  endfunction

  function automatic mapper_t map_code(input int i);
    case (i)
      0:       return MAP_HIROM;
      1:       return MAP_LOROM;
      2:       return MAP_EXHIROM;
      3:       return MAP_MENU;
      default: return MAP_BSX;
    endcase
  endfunction

  // Random address inside the save RAM window of a mapper
  function automatic snes_addr_t save_addr(input mapper_t m);
    logic [23:0] v;
    v = rand_bits(24);
    if (m == MAP_LOROM) begin
      v[22:20] = 3'b111;
      v[15]    = 1'b0;
      if (v[19:16] >= 4'hE) v[19] = 1'b0;
    end else if (m == MAP_BSX) begin
      v[23:19] = 5'b00010;
      v[15:12] = 4'h5;
    end else begin
      v[22]    = 1'b0;
      v[21]    = 1'b1;
      v[15:13] = 3'b011;
    end
    return v;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic predict(input snes_addr_t a, input pa_t pa);
    logic      win, hi, psram, cart, hole;
    mem_addr_t bx, menu_off;
    hi = m_bsx[2];
    case (m_map)
      MAP_LOROM: win = (a[22:20] == 3'b111) && (a[19:16] <= 4'hD) && (!a[15] || !m_rmask[21]);
      MAP_BSX:   win = (a[23:19] == 5'b00010) && (a[15:12] == 4'h5);
      MAP_HIROM, MAP_EXHIROM, MAP_MENU: win = !a[22] && a[21] && (a[15:13] == 3'b011);
      default:   win = 1'b0;
    endcase
    e_sav = m_smask[0] && win;
    e_rom = a[22] || a[15];
    e_bsx = (m_map == MAP_BSX);
    // PSRAM bank from regs 5/6 plus the fixed extra window of each layout
    if (hi)
      psram = ((a[22:20] == {1'b1, m_bsx[6], m_bsx[5]}) && !a[19])
           || ((a[22:21] == 2'b01) && (a[15:13] == 3'b011));
    else
      psram = ((a[22:21] == {m_bsx[6], m_bsx[5]}) && a[15]) || ((a[22:20] == 3'b111) && !a[15]);
    psram = psram && (a[23] ? m_bsx[4] : m_bsx[3]);
    cart  = a[15] && !a[22] && (a[23] ? m_bsx[8] : m_bsx[7]);
    hole  = (a[23] ? m_bsx[10] : m_bsx[9])
         && (hi ? (a[21:20] == {m_bsx[11], 1'b0}) : (a[22:21] == {m_bsx[11], 1'b0}));
    e_tri = e_bsx && hole && !cart && !psram;
    e_wr  = e_sav || (e_bsx && psram);
    e_hit = e_rom || e_wr;
    bx       = hi ? {1'b0, a[22:0]} : {2'b00, a[22:16], a[14:0]};
    menu_off = {9'd0, a[14:0]} - 24'h006000;
    case (m_map)
      MAP_HIROM:   e_addr = e_sav ? SR_BASE + ({6'd0, a[20:16], a[12:0]} & m_smask)
                                  : {1'b0, a[22:0]} & m_rmask;
      MAP_LOROM:   e_addr = e_sav ? SR_BASE + ({4'd0, a[20:16], a[14:0]} & m_smask)
                                  : {2'b00, a[22:16], a[14:0]} & m_rmask;
      MAP_EXHIROM: e_addr = e_sav ? SR_BASE + ({6'd0, a[20:16], a[12:0]} & m_smask)
                                  : {1'b0, ~a[23], a[21:0]} & m_rmask;
      MAP_MENU:    e_addr = e_sav ? 24'hFF0000 + (menu_off & m_smask)
                                  : ({1'b0, a[22:0]} & m_rmask) + 24'hC00000;
      MAP_BSX: begin
        if (e_sav)      e_addr = SR_BASE + {9'd0, a[18:16], a[11:0]};
        else if (cart)  e_addr = 24'h800000 + ({2'b00, a[22:16], a[14:0]} & 24'h0FFFFF);
        else if (psram) e_addr = PS_BASE + (bx & 24'h07FFFF);
        else            e_addr = bx & 24'h0FFFFF;
      end
      default: e_addr = '0;
    endcase
    e_msu   = m_feat[FEAT_MSU1] && !a[22] && (a[15:0] >= 16'h2000) && (a[15:0] <= 16'h2007);
    e_srtc  = m_feat[FEAT_SRTC] && !a[22] && ((a[15:0] == 16'h2800) || (a[15:0] == 16'h2801));
    e_213f  = m_feat[FEAT_213F] && (pa == 8'h3F);
    e_cmdrd = (pa[7:4] == 4'hE);
    e_cmdwr = (a[23:4] == 20'hCCCCC);
  endtask

  //////////////////////////////
  // Drivers and checks
  //////////////////////////////

  task automatic compare(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_outputs();
    compare("rom_addr", rom_addr, e_addr);
    compare("rom_hit", 24'(rom_hit), 24'(e_hit));
    compare("is_rom", 24'(is_rom), 24'(e_rom));
    compare("is_saveram", 24'(is_saveram), 24'(e_sav));
    compare("is_writable", 24'(is_writable), 24'(e_wr));
    compare("use_bsx", 24'(use_bsx), 24'(e_bsx));
    compare("bsx_tristate", 24'(bsx_tristate), 24'(e_tri));
    compare("msu_enable", 24'(msu_enable), 24'(e_msu));
    compare("srtc_enable", 24'(srtc_enable), 24'(e_srtc));
    compare("r213f_enable", 24'(r213f_enable), 24'(e_213f));
    compare("snescmd_rd_enable", 24'(snescmd_rd_enable), 24'(e_cmdrd));
    compare("snescmd_wr_enable", 24'(snescmd_wr_enable), 24'(e_cmdwr));
  endtask

  // Present one address and check the result after the next edge
  task automatic apply(input snes_addr_t a, input pa_t pa);
    @(posedge clk);
    snes_addr <= a;
    snes_pa   <= pa;
    predict(a, pa);
    @(posedge clk);
    @(negedge clk);
    check_outputs();
  endtask

  task automatic mcu_write(input cfg_sel_t sel, input logic [7:0] d);
    @(posedge clk);
    mcu_wr   <= 1'b1;
    mcu_sel  <= sel;
    mcu_data <= d;
    @(posedge clk);
    mcu_wr <= 1'b0;
    case (sel)
      3'd0:             m_map = d[2:0];
      3'd1:             m_feat = d;
      3'd2, 3'd3, 3'd4: m_rmask[8 * (sel - 2) +: 8] = d;
      default:          m_smask[8 * (sel - 5) +: 8] = d;
    endcase
  endtask

  task automatic write_mask(input cfg_sel_t base, input mask_t v);
    mcu_write(base, v[7:0]);
    mcu_write(base + 3'd1, v[15:8]);
    mcu_write(base + 3'd2, v[23:16]);
  endtask

  task automatic snes_write(input snes_addr_t a, input logic [7:0] d);
    @(posedge clk);
    snes_wr   <= 1'b1;
    snes_addr <= a;
    snes_data <= d;
    @(posedge clk);
    snes_wr <= 1'b0;
    if ((a[23:16] >= 8'h01) && (a[23:16] <= 8'h0E) && (a[15:12] == 4'h5))
      m_bsx[a[19:16]] = d[7];  // Data bit 7 only
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, test_errs);
      n_failed++;
    end
    errs += test_errs;
    test_errs = 0;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    arst_n    = 1'b0;
    mcu_wr    = 1'b0;
    mcu_sel   = '0;
    mcu_data  = '0;
    snes_wr   = 1'b0;
    snes_addr = '0;
    snes_data = '0;
    snes_pa   = '0;
    lfsr      = 16'd25453;
    m_map     = MAP_HIROM;
    m_feat    = '0;
    m_rmask   = 24'hFFFFFF;
    m_smask   = '0;
    m_bsx     = '0;
    errs      = 0;
    test_errs = 0;
    n_tests   = 0;
    n_failed  = 0;

    repeat (7) @(posedge clk);
    @(negedge clk);
    {e_addr, e_hit, e_rom, e_sav, e_wr, e_bsx, e_tri, e_msu, e_srtc, e_213f, e_cmdrd,
     e_cmdwr} = '0;
    check_outputs();
    @(posedge clk);
    arst_n <= 1'b1;
    apply(24'h808000, 8'h00);
    compare("rom_addr", rom_addr, 24'h008000);
    compare("rom_hit", 24'(rom_hit), 24'd1);
    end_test("reset and default map");

    for (int m = 0; m < 4; m++) begin
      mcu_write(3'd0, {5'd0, map_code(m)});
      write_mask(3'd2, rand_bits(24));
      repeat (N_VEC) begin
        r = rand_bits(24);
        q = rand_bits(8);
        apply(r, q[7:0]);
      end
    end
    end_test("rom mapping");

    for (int sweep = 0; sweep < 2; sweep++) begin
      r    = rand_bits(24);
      r[0] = (sweep == 0);  // Enable bit on the first sweep only
      write_mask(3'd5, r);
      for (int m = 0; m < 5; m++) begin
        mcu_write(3'd0, {5'd0, map_code(m)});
        repeat (N_VEC) begin
          apply(save_addr(map_code(m)), 8'h00);
          compare("is_saveram", 24'(is_saveram), 24'(sweep == 0));
        end
      end
    end
    end_test("save ram");

    mcu_write(3'd0, {5'd0, MAP_BSX});
    repeat (N_VEC) begin
      r        = rand_bits(24);
      r[23:20] = 4'h0;
      r[15:12] = 4'h5;
      if (r[19:16] == 4'h0) r[16] = 1'b1;
      if (r[19:16] == 4'hF) r[16] = 1'b0;
      q = rand_bits(8);
      snes_write(r, q[7:0]);
      // Second write misses the register window by its bank or by its offset
      q = rand_bits(5);
      if (q[4])
        r[23:20] = (q[3:0] == 4'h0) ? 4'h1 : q[3:0];
      else
        r[15:12] = (q[3:0] == 4'h5) ? 4'h4 : q[3:0];
      snes_write(r, 8'h80);
      repeat (2) begin
        r = rand_bits(24);
        q = rand_bits(8);
        apply(r, q[7:0]);
      end
    end
    end_test("bs-x mapping");

    for (int k = 0; k < 4; k++) begin
      q = rand_bits(8);
      mcu_write(3'd1, (k == 0) ? 8'h1C : (k == 1) ? 8'h00 : q[7:0]);
      repeat (N_VEC) begin
        r = rand_bits(24);
        q = rand_bits(12);
        p = q[11:4];
        case (q[1:0])
          2'd0:    r[15:0] = {13'h0400, r[2:0]};
          2'd1:    r[15:0] = {15'h1400, r[0]};
          2'd2:    r[23:4] = 20'hCCCCC;
          default: ;
        endcase
        if (q[3:2] == 2'd0) p = 8'h3F;
        if (q[3:2] == 2'd1) p[7:4] = 4'hE;
        apply(r, p);
      end
    end
    end_test("peripherals");

    $display("tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, errs);
    if (n_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
